//--- const_pack.sv
/*
 * shared sizes and bus types for the ti-adc back end
 * slice bus, replica bus, sample bus, control and monitor words
 * configuration write union and register addresses
 */

package const_pack;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////
    localparam int n_adc = 8;    // magnitude bits per slice
    localparam int n_ti  = 16;   // interleaved slices, multiple of 4

    //////////////////////////////////////////////////
    // data buses
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [n_ti-1:0][n_adc-1:0] data;   // magnitudes
        logic [n_ti-1:0]            sign;   // 1 = negative
    } slice_bus_t;                          // 144 bits

    typedef struct packed {
        logic [1:0][n_adc-1:0] data;        // replica magnitudes
        logic [1:0]            sign;
    } rep_bus_t;                            // 18 bits

    typedef logic signed [n_adc:0] sample_t;  // one two's-complement sample

    typedef struct packed {
        sample_t [n_ti-1:0] word;           // index = output slice
    } sample_bus_t;                         // 144 bits

    //////////////////////////////////////////////////
    // configuration
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [n_ti-1:0] mux_ctrl_1;        // 1 = direct, 0 = latch
        logic [n_ti-1:0] mux_ctrl_2;        // 1 = flop 1, 0 = flop 2
    } retimer_ctrl_t;

    typedef struct packed {
        logic [15:0] window_len;            // cycles per window
        logic [15:0] threshold;             // alarm when count above this
    } mon_cfg_t;

    // same 32-bit write word, meaning depends on address
    typedef union packed {
        retimer_ctrl_t mux;
        mon_cfg_t      mon;
    } cfg_word_u;

    localparam logic cfg_addr_mux = 1'b0;
    localparam logic cfg_addr_mon = 1'b1;

endpackage

//--- ti_adc_retimer.sv
/*
 * ti-adc slice retimer
 * transpose reorder of 16 slices, clock-high latch,
 * per-slice latency select over two flops, replica flops
 */

`timescale 1ns/10ps
`default_nettype none

module ti_adc_retimer (
    input  wire logic                      clk_retimer,
    input  wire const_pack::slice_bus_t    slices_in,    // raw slice outputs
    input  wire const_pack::rep_bus_t      reps_in,      // replica slice outputs
    input  wire const_pack::retimer_ctrl_t retimer_ctrl,
    output const_pack::slice_bus_t         slices_out,   // sample order, retimed
    output const_pack::rep_bus_t           reps_out
);

    localparam int n_adc = const_pack::n_adc;
    localparam int n_ti  = const_pack::n_ti;
    localparam int grp   = n_ti / 4;    // slices per group in the transpose

    // per-slice results, packed back into the bus below
    logic [n_adc-1:0] out_data [n_ti];
    logic             out_sign [n_ti];

    //////////////////////////////////////////////////
    // main slices
    //////////////////////////////////////////////////
    genvar k;
    generate
        for (k = 0; k < n_ti; k++) begin : g_slice
            localparam int src = (k % 4) * grp + k / 4;   // transpose source

            logic [n_adc-1:0] reo_data;     // reordered input
            logic             reo_sign;
            logic [n_adc-1:0] lat_data;     // clock-high latch
            logic             lat_sign;
            logic [n_adc-1:0] m1_data;      // mux 1 out
            logic             m1_sign;
            logic [n_adc-1:0] f1_data;      // first flop
            logic             f1_sign;
            logic [n_adc-1:0] f2_data;      // second flop, extra cycle
            logic             f2_sign;

            assign reo_data = slices_in.data[src];
            assign reo_sign = slices_in.sign[src];

            // transparent while clk high, holds through low phase
            always_latch begin
                if (clk_retimer) begin
                    lat_data <= reo_data;
                    lat_sign <= reo_sign;
                end
            end

            // mux 1 picks direct input or latch
            always_comb begin
                m1_data = retimer_ctrl.mux_ctrl_1[k] ? reo_data : lat_data;
                m1_sign = retimer_ctrl.mux_ctrl_1[k] ? reo_sign : lat_sign;
            end

            // flop cascade, no reset
            always_ff @(posedge clk_retimer) begin
                f1_data <= m1_data;
                f1_sign <= m1_sign;
                f2_data <= f1_data;
                f2_sign <= f1_sign;
            end

            // mux 2 sets latency: 1 edge or 2 edges
            always_comb begin
                out_data[k] = retimer_ctrl.mux_ctrl_2[k] ? f1_data : f2_data;
                out_sign[k] = retimer_ctrl.mux_ctrl_2[k] ? f1_sign : f2_sign;
            end
        end
    endgenerate

    // gather slices into the output bus
    always_comb begin
        for (int i = 0; i < n_ti; i++) begin
            slices_out.data[i] = out_data[i];
            slices_out.sign[i] = out_sign[i];
        end
    end

    //////////////////////////////////////////////////
    // replicas
    //////////////////////////////////////////////////
    // both replicas on the same edge, skew shows up as disagreement
    always_ff @(posedge clk_retimer) begin
        reps_out <= reps_in;   // single flop each
    end

endmodule

`default_nettype wire

//--- slice_sample_formatter.sv
/*
 * sign-magnitude to two's-complement conversion
 * all slices in parallel, one registered stage
 */

`timescale 1ns/10ps
`default_nettype none

module slice_sample_formatter (
    input  wire logic                   clk_retimer,
    input  wire logic                   reset,
    input  wire const_pack::slice_bus_t slices,    // retimed, sample order
    output const_pack::sample_bus_t     samples     // signed, n_adc+1 bits each
);

    localparam int n_ti  = const_pack::n_ti;

    const_pack::sample_bus_t samples_d;    // next-state conversion

    //////////////////////////////////////////////////
    // conversion
    //////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < n_ti; i++) begin
            // zero-extend so full-scale magnitude still fits once negated
            if (slices.sign[i]) begin
                samples_d.word[i] = -$signed({1'b0, slices.data[i]});   // -0 folds to 0
            end else begin
                samples_d.word[i] = $signed({1'b0, slices.data[i]});
            end
        end
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////
    always_ff @(posedge clk_retimer) begin
        if (reset) begin
            samples <= '0;
        end else begin
            samples <= samples_d;   // one cycle after retimer
        end
    end

endmodule

`default_nettype wire

//--- replica_skew_monitor.sv
/*
 * replica skew monitor
 * counts replica disagreements per window of window_len cycles,
 * publishes count and alarm at each window end
 */

`timescale 1ns/10ps
`default_nettype none

module replica_skew_monitor #(
    parameter int cnt_width = 16    // mismatch counter width
) (
    input  wire logic                 clk_retimer,
    input  wire logic                 reset,
    input  wire const_pack::rep_bus_t reps,          // retimed replicas
    input  wire const_pack::mon_cfg_t mon_cfg,
    output logic                      skew_alarm,     // count above threshold
    output logic [cnt_width-1:0]      mismatch_count  // last window total
);

    logic [15:0]          win_cnt;     // cycle within window
    logic [cnt_width-1:0] acc;         // mismatches so far this window
    logic                 mismatch;    // replicas differ this cycle
    logic                 win_last;    // final cycle of window
    logic [cnt_width-1:0] acc_next;    // acc including this cycle

    //////////////////////////////////////////////////
    // per-cycle decode
    //////////////////////////////////////////////////
    assign mismatch = (reps.data[0] != reps.data[1]) || (reps.sign[0] != reps.sign[1]);

    // >= so a shorter window written mid-count still closes
    assign win_last = ({1'b0, win_cnt} + 17'd1) >= {1'b0, mon_cfg.window_len};

    // saturate instead of wrapping
    assign acc_next = (mismatch && (acc != '1)) ? acc + 1'b1 : acc;

    //////////////////////////////////////////////////
    // counters and outputs
    //////////////////////////////////////////////////
    always_ff @(posedge clk_retimer) begin
        if (reset) begin
            win_cnt        <= '0;
            acc            <= '0;
            mismatch_count <= '0;
            skew_alarm     <= 1'b0;
        end else if (win_last) begin
            win_cnt        <= '0;            // restart window
            acc            <= '0;
            mismatch_count <= acc_next;      // window total
            skew_alarm     <= acc_next > mon_cfg.threshold;
        end else begin
            win_cnt        <= win_cnt + 16'd1;
            acc            <= acc_next;      // outputs hold
        end
    end

endmodule

`default_nettype wire

//--- retimer_config_regs.sv
/*
 * configuration register block
 * retimer mux controls at address 0, monitor window/threshold at 1,
 * single-strobe write of a union word
 */

`timescale 1ns/10ps
`default_nettype none

module retimer_config_regs (
    input  wire logic                  clk_retimer,
    input  wire logic                  reset,
    input  wire logic                  cfg_wr,        // one-cycle write strobe
    input  wire logic                  cfg_addr,
    input  wire const_pack::cfg_word_u cfg_wdata,     // view picked by cfg_addr
    output const_pack::retimer_ctrl_t  retimer_ctrl,
    output const_pack::mon_cfg_t       mon_cfg
);

    localparam int n_ti = const_pack::n_ti;

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk_retimer) begin
        if (reset) begin
            retimer_ctrl.mux_ctrl_1 <= {n_ti{1'b1}};   // direct path
            retimer_ctrl.mux_ctrl_2 <= {n_ti{1'b0}};   // 2-edge path
            mon_cfg.window_len      <= 16'd64;
            mon_cfg.threshold       <= 16'd0;
        end else if (cfg_wr) begin
            case (cfg_addr)
                const_pack::cfg_addr_mux: begin
                    retimer_ctrl <= cfg_wdata.mux;
                end
                const_pack::cfg_addr_mon: begin
                    mon_cfg <= cfg_wdata.mon;
                end
                default: begin
                    // unknown address, nothing written
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- ti_adc_backend_top.sv
/*
 * ti-adc back end top level
 * config registers -> retimer -> formatter, replicas -> skew monitor
 */

`timescale 1ns/10ps
`default_nettype none

module ti_adc_backend_top #(
    parameter int cnt_width = 16    // mismatch counter width
) (
    input  wire logic                   clk_retimer,
    input  wire logic                   reset,
    input  wire const_pack::slice_bus_t slices,        // slice outputs
    input  wire const_pack::rep_bus_t   replicas,      // replica outputs
    input  wire logic                   cfg_wr,
    input  wire logic                   cfg_addr,
    input  wire const_pack::cfg_word_u  cfg_wdata,
    output const_pack::sample_bus_t     samples,       // two's complement
    output logic                        skew_alarm,
    output logic [cnt_width-1:0]        mismatch_count
);

    const_pack::retimer_ctrl_t retimer_ctrl;   // regs -> retimer
    const_pack::mon_cfg_t      mon_cfg;        // regs -> monitor
    const_pack::slice_bus_t    slices_rt;      // retimed slices
    const_pack::rep_bus_t      reps_rt;        // retimed replicas

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    retimer_config_regs u_config_regs (
        .clk_retimer  (clk_retimer),
        .reset        (reset),
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .retimer_ctrl (retimer_ctrl),
        .mon_cfg      (mon_cfg)
    );

    //////////////////////////////////////////////////
    // data path
    //////////////////////////////////////////////////
    ti_adc_retimer u_retimer (
        .clk_retimer  (clk_retimer),
        .slices_in    (slices),
        .reps_in      (replicas),
        .retimer_ctrl (retimer_ctrl),
        .slices_out   (slices_rt),
        .reps_out     (reps_rt)
    );

    slice_sample_formatter u_formatter (
        .clk_retimer (clk_retimer),
        .reset       (reset),
        .slices      (slices_rt),
        .samples     (samples)       // +1 cycle
    );

    // skew check on the replica pair
    replica_skew_monitor #(
        .cnt_width (cnt_width)
    ) u_monitor (
        .clk_retimer    (clk_retimer),
        .reset          (reset),
        .reps           (reps_rt),
        .mon_cfg        (mon_cfg),
        .skew_alarm     (skew_alarm),
        .mismatch_count (mismatch_count)
    );

endmodule

`default_nettype wire

//--- tb_ti_adc_backend.sv
/*
 * self-checking testbench for the ti-adc back end
 * test list from the input data file, random slice data,
 * reference model for reorder, latency, sign conversion and skew windows
 */

`timescale 1ns/10ps

module tb_ti_adc_backend;

    localparam int n_adc     = const_pack::n_adc;
    localparam int n_ti      = const_pack::n_ti;
    localparam int cnt_width = 16;

    logic                      clk_retimer;
    logic                      reset;
    const_pack::slice_bus_t    slices;
    const_pack::rep_bus_t      replicas;
    logic                      cfg_wr;
    logic                      cfg_addr;
    const_pack::cfg_word_u     cfg_wdata;
    const_pack::sample_bus_t   samples;
    logic                      skew_alarm;
    logic [cnt_width-1:0]      mismatch_count;

    integer seed;                           // $random state
    int     checks;                         // compares done, whole run
    int     test_errs;                      // errors in the running test
    int     err_total;
    int     fail_tests;
    int     wd_cycles;                      // watchdog limit, 0 until loaded
    string  cur_name;

    // test list, one entry per data line
    string        t_name[$];
    logic [31:0]  t_mux[$];
    logic [31:0]  t_mon[$];
    int           t_len[$];
    logic [127:0] t_pat[$];                 // bit c = replicas differ in vector c

    const_pack::slice_bus_t stim_q[$];      // vectors driven in this test

    ti_adc_backend_top #(
        .cnt_width (cnt_width)
    ) u_ti_adc_backend_top (
        .clk_retimer    (clk_retimer),
        .reset          (reset),
        .slices         (slices),
        .replicas       (replicas),
        .cfg_wr         (cfg_wr),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .samples        (samples),
        .skew_alarm     (skew_alarm),
        .mismatch_count (mismatch_count)
    );

    initial clk_retimer = 1'b0;
    always #50 clk_retimer = ~clk_retimer;  // 100 ns period

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic const_pack::sample_t to_twos(input logic [n_adc-1:0] mag,
                                                    input logic neg);
        int v;
        v = mag;
        if (neg) v = 0 - v;                 // negative zero stays 0
        return v[n_adc:0];
    endfunction

    // output slice k comes from input (k mod 4)*4 + k/4, 2 or 3 edges back
    function automatic const_pack::sample_bus_t expected_samples(
        input int c, input const_pack::retimer_ctrl_t rc);
        const_pack::sample_bus_t e;
        int src_v;
        int src_s;
        for (int k = 0; k < n_ti; k++) begin
            src_v = rc.mux_ctrl_2[k] ? c - 2 : c - 3;
            src_s = (k % 4) * (n_ti / 4) + k / 4;
            if (src_v < 0) begin
                e.word[k] = '0;             // quiet inputs before the test
            end else begin
                e.word[k] = to_twos(stim_q[src_v].data[src_s], stim_q[src_v].sign[src_s]);
            end
        end
        return e;
    endfunction

    // mismatches in window w, monitor edge j sees vector j-4
    function automatic logic [cnt_width-1:0] window_total(input int w, input int wlen,
                                                           input logic [127:0] pat,
                                                           input int n);
        logic [cnt_width-1:0] sum;
        int c;
        sum = '0;
        for (int j = (w - 1) * wlen + 1; j <= w * wlen; j++) begin
            c = j - 4;
            if (c >= 0 && c < n && pat[c]) sum = sum + 1'b1;
        end
        return sum;
    endfunction

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    function automatic const_pack::slice_bus_t make_vector(input int c);
        const_pack::slice_bus_t v;
        logic [31:0] r;
        for (int i = 0; i < n_ti; i++) begin
            r = $random(seed);
            v.data[i] = r[n_adc-1:0];
            v.sign[i] = r[n_adc];
        end
        if (c == 0) begin                   // full scale, odd slices negative
            v.data = '1;
            v.sign = 16'haaaa;
        end else if (c == 1) begin          // negative zero everywhere
            v.data = '0;
            v.sign = '1;
        end else if (c == 2) begin          // full scale, even slices negative
            v.data = '1;
            v.sign = 16'h5555;
        end
        return v;
    endfunction

    function automatic const_pack::rep_bus_t make_replicas(input int c, input logic differ);
        const_pack::rep_bus_t rp;
        logic [31:0] r;
        r = $random(seed);
        rp.data[0] = r[n_adc-1:0];
        rp.data[1] = r[n_adc-1:0];
        rp.sign    = {2{r[n_adc]}};
        if (differ && c[0]) rp.sign[1] = ~r[n_adc];            // sign skew
        if (differ && !c[0]) rp.data[1] = ~r[n_adc-1:0];       // data skew
        return rp;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_sample(input const_pack::sample_bus_t exp_s,
                                input const_pack::sample_bus_t act_s, input int cyc);
        checks++;
        if (act_s !== exp_s) begin
            $display("** Error: %s cycle %0d samples, expected %h, actual %h",
                     cur_name, cyc, exp_s, act_s);
            test_errs++;
        end
    endtask

    task automatic check_monitor(input logic [cnt_width-1:0] exp_cnt, input logic exp_alarm,
                                 input logic [cnt_width-1:0] act_cnt, input logic act_alarm,
                                 input int cyc);
        checks++;
        if (act_cnt !== exp_cnt || act_alarm !== exp_alarm) begin
            $display("** Error: %s cycle %0d count/alarm, expected %0d/%b, actual %0d/%b",
                     cur_name, cyc, exp_cnt, exp_alarm, act_cnt, act_alarm);
            test_errs++;
        end
    endtask

    //////////////////////////////////////////////////
    // test list and test run
    //////////////////////////////////////////////////
    task automatic load_tests(output int ok);
        int fd;
        int n;
        int cnt;
        string line;
        string name;
        logic [31:0] mux_w;
        logic [31:0] mon_w;
        logic [127:0] pat;
        ok = 0;
        fd = $fopen("adc_backend_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open adc_backend_input.txt");
            return;
        end
        while ($fgets(line, fd)) begin
            if (line.len() > 0 && line.getc(0) == "#") continue;   // column notes
            cnt = $sscanf(line, "%s %h %h %d %h", name, mux_w, mon_w, n, pat);
            if (cnt == 5) begin
                t_name.push_back(name);
                t_mux.push_back(mux_w);
                t_mon.push_back(mon_w);
                t_len.push_back(n);
                t_pat.push_back(pat);
                wd_cycles += n + 20;        // run length budget
            end else if (cnt > 0) begin
                $display("bad line in test list: %s", line);
                err_total++;
            end
        end
        $fclose(fd);
        ok = (t_name.size() > 0);
    endtask

    task automatic run_test(input int t);
        const_pack::retimer_ctrl_t rc;
        const_pack::mon_cfg_t      mc;
        const_pack::slice_bus_t    v;
        logic [cnt_width-1:0]      exp_cnt;
        logic                      exp_alarm;
        int                        w;
        int                        wl;
        cur_name  = t_name[t];
        rc        = t_mux[t];
        mc        = t_mon[t];
        wl        = mc.window_len;
        test_errs = 0;
        stim_q.delete();
        reset    = 1'b1;                    // 8 cycles, quiet inputs flush retimer
        slices   = '0;
        replicas = '0;
        cfg_wr   = 1'b0;
        repeat (8) @(posedge clk_retimer);
        #5;
        check_sample('0, samples, -1);      // cleared by reset
        check_monitor('0, 1'b0, mismatch_count, skew_alarm, -1);
        reset         = 1'b0;
        cfg_wr        = 1'b1;
        cfg_addr      = const_pack::cfg_addr_mon;
        cfg_wdata.mon = mc;
        @(posedge clk_retimer);
        #5;
        cfg_addr      = const_pack::cfg_addr_mux;
        cfg_wdata.mux = rc;
        for (int c = 0; c < t_len[t]; c++) begin
            @(posedge clk_retimer);
            #5;
            cfg_wr = 1'b0;
            check_sample(expected_samples(c, rc), samples, c);
            w = (c + 2) / wl;               // windows closed so far
            exp_cnt   = (w == 0) ? '0 : window_total(w, wl, t_pat[t], t_len[t]);
            exp_alarm = (w != 0) && (exp_cnt > mc.threshold);
            check_monitor(exp_cnt, exp_alarm, mismatch_count, skew_alarm, c);
            v = make_vector(c);
            stim_q.push_back(v);
            slices   = v;
            replicas = make_replicas(c, t_pat[t][c]);
        end
        if (test_errs == 0) begin
            $display("%s: %0d vectors, ok", cur_name, t_len[t]);
        end else begin
            $display("%s: %0d vectors, %0d errors", cur_name, t_len[t], test_errs);
            fail_tests++;
        end
        err_total += test_errs;
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////
    initial begin
        int ok;
        reset      = 1'b1;
        slices     = '0;
        replicas   = '0;
        cfg_wr     = 1'b0;
        cfg_addr   = 1'b0;
        cfg_wdata  = '0;
        seed       = 32'he0e6_763c;
        checks     = 0;
        err_total  = 0;
        fail_tests = 0;
        wd_cycles  = 0;
        load_tests(ok);
        if (!ok) begin
            $display("no usable test lines, nothing was run");
            $display("TEST FAILED");
            $finish;
        end else begin
            for (int t = 0; t < t_name.size(); t++) run_test(t);
            $display("tests %0d, failing %0d, checks %0d, errors %0d",
                     t_name.size(), fail_tests, checks, err_total);
            if (err_total == 0 && fail_tests == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk_retimer);
        $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- adc_backend_input.txt
# columns: name, mux word {mux_ctrl_1, mux_ctrl_2} hex, monitor word {window_len, threshold} hex,
# vector count decimal, replica mismatch pattern hex (bit c set = replicas differ in vector c)
reset_defaults   ffff0000 00400000 40 0
fast_path        ffffffff 00400000 40 0
mixed_latency    ffffa5c3 00400000 40 0
latch_slow       00000000 00400000 40 0
latch_fast       0000ffff 00400000 40 0
latch_mixed      0f0f3c96 00400000 40 0
mon_clean        ffff0000 00080000 48 0
mon_single       ffff0000 00080000 48 000000100000
mon_threshold    ffff0000 00080002 56 00e000c0007000e
mon_burst        ffffffff 000c0004 60 00000000fffffff
mon_high_thr     ffff0000 0006ffff 40 fffffffffff
mon_latch_mixed  5a5a0ff0 00050001 50 0001803300c0601

//--- src.f
const_pack.sv
ti_adc_retimer.sv
slice_sample_formatter.sv
replica_skew_monitor.sv
retimer_config_regs.sv
ti_adc_backend_top.sv
tb_ti_adc_backend.sv
